//--- hdl/rd_guard_pkg.sv
// Read guard sizes, register offsets and the status word union
package rd_guard_pkg;

  // Tracking table sizes
  localparam int ID_CAPACITY = 4;
  localparam int ID_W        = 4;
  localparam int NUM_TXN_W   = 4;
  localparam int CNT_W       = 16;
  localparam int IDX_W       = 2;

  // Register bus widths
  localparam int REG_AW = 4;
  localparam int REG_DW = 32;

  // Width of the reset-cause counter
  localparam int RST_CNT_W = 8;

  // Register byte offsets
  localparam logic [REG_AW-1:0] ADDR_STATUS = 4'h0;
  localparam logic [REG_AW-1:0] ADDR_BUDGET = 4'h4;
  localparam logic [REG_AW-1:0] ADDR_RESET  = 4'h8;

  // Latency budget after reset, in cycles
  localparam logic [CNT_W-1:0] BUDGET_RESET = 16'd20;

  // Status word, seen either as the raw bus word or by field
  typedef union packed {
    logic [REG_DW-1:0] raw;
    struct packed {
      logic [REG_DW-ID_W-5:0] rsvd_hi;
      logic [ID_W-1:0]        txn_id;
      logic                   rsvd_b3;
      logic                   irq;
      logic                   rd_timeout;
      logic                   unwanted_rd_resp;
    } fields;
  } rd_status_u;

endpackage

//--- hdl/rd_id_table.sv
// ID tracking table storage with budget countdown, free-slot and ID match search
`timescale 1ns/1ps

module rd_id_table (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  input  logic [rd_guard_pkg::ID_W-1:0]                           ar_id_i,
  input  logic [rd_guard_pkg::ID_W-1:0]                           r_id_i,
  input  logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::ID_W-1:0]      entry_id_d_i,
  input  logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::NUM_TXN_W-1:0] entry_num_d_i,
  input  logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::CNT_W-1:0]     entry_budget_d_i,
  input  logic [rd_guard_pkg::ID_CAPACITY-1:0]                    entry_free_d_i,
  output logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::ID_W-1:0]      entry_id_q_o,
  output logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::NUM_TXN_W-1:0] entry_num_q_o,
  output logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::CNT_W-1:0]     entry_budget_q_o,
  output logic [rd_guard_pkg::ID_CAPACITY-1:0]                    entry_free_q_o,
  output logic                                                    ar_match_o,
  output logic [rd_guard_pkg::IDX_W-1:0]                          ar_match_idx_o,
  output logic                                                    full_o,
  output logic [rd_guard_pkg::IDX_W-1:0]                          free_idx_o,
  output logic                                                    rsp_hit_o,
  output logic [rd_guard_pkg::IDX_W-1:0]                          rsp_idx_o
);

  logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::CNT_W-1:0] budget_nxt;

  // Countdown only for entries that stay in use across this edge,
  // so a freshly loaded entry keeps its full budget for one cycle
  always_comb begin
    for (int i = 0; i < rd_guard_pkg::ID_CAPACITY; i++) begin
      budget_nxt[i] = entry_budget_d_i[i];
      if (!entry_free_q_o[i] && !entry_free_d_i[i] && (entry_budget_d_i[i] != '0)) begin
        budget_nxt[i] = entry_budget_d_i[i] - 1'b1;
      end
    end
  end

  // Occupancy and open-read counts
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      entry_free_q_o <= '1;
      entry_num_q_o  <= '0;
    end else begin
      entry_free_q_o <= entry_free_d_i;
      entry_num_q_o  <= entry_num_d_i;
    end
  end

  // Entry payload, only meaningful while the entry is in use
  always_ff @(posedge clk_i) begin
    entry_id_q_o     <= entry_id_d_i;
    entry_budget_q_o <= budget_nxt;
  end

  // Searches run from the top down so the lowest index wins
  always_comb begin
    full_o         = 1'b1;
    free_idx_o     = '0;
    ar_match_o     = 1'b0;
    ar_match_idx_o = '0;
    rsp_hit_o      = 1'b0;
    rsp_idx_o      = '0;
    for (int i = rd_guard_pkg::ID_CAPACITY - 1; i >= 0; i--) begin
      if (entry_free_q_o[i]) begin
        full_o     = 1'b0;
        free_idx_o = i[rd_guard_pkg::IDX_W-1:0];
      end else begin
        if (entry_id_q_o[i] == ar_id_i) begin
          ar_match_o     = 1'b1;
          ar_match_idx_o = i[rd_guard_pkg::IDX_W-1:0];
        end
        if (entry_id_q_o[i] == r_id_i) begin
          rsp_hit_o = 1'b1;
          rsp_idx_o = i[rd_guard_pkg::IDX_W-1:0];
        end
      end
    end
  end

endmodule

//--- hdl/rd_txn_manager.sv
// Read transaction manager: table next state, timeout and unwanted response detection
`timescale 1ns/1ps

module rd_txn_manager (
  input  logic                                                    ar_fire_i,
  input  logic                                                    r_done_i,
  input  logic [rd_guard_pkg::ID_W-1:0]                           ar_id_i,
  input  logic [rd_guard_pkg::ID_W-1:0]                           r_id_i,
  input  logic [rd_guard_pkg::CNT_W-1:0]                          budget_i,
  input  logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::ID_W-1:0]      entry_id_q_i,
  input  logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::NUM_TXN_W-1:0] entry_num_q_i,
  input  logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::CNT_W-1:0]     entry_budget_q_i,
  input  logic [rd_guard_pkg::ID_CAPACITY-1:0]                    entry_free_q_i,
  input  logic                                                    ar_match_i,
  input  logic [rd_guard_pkg::IDX_W-1:0]                          ar_match_idx_i,
  input  logic                                                    full_i,
  input  logic [rd_guard_pkg::IDX_W-1:0]                          free_idx_i,
  input  logic                                                    rsp_hit_i,
  input  logic [rd_guard_pkg::IDX_W-1:0]                          rsp_idx_i,
  output logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::ID_W-1:0]      entry_id_d_o,
  output logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::NUM_TXN_W-1:0] entry_num_d_o,
  output logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::CNT_W-1:0]     entry_budget_d_o,
  output logic [rd_guard_pkg::ID_CAPACITY-1:0]                    entry_free_d_o,
  output logic                                                    set_timeout_o,
  output logic                                                    set_unwanted_o,
  output logic                                                    reset_req_o,
  output logic [rd_guard_pkg::ID_W-1:0]                           evt_id_o
);

  always_comb begin
    entry_id_d_o     = entry_id_q_i;
    entry_num_d_o    = entry_num_q_i;
    entry_budget_d_o = entry_budget_q_i;
    entry_free_d_o   = entry_free_q_i;
    set_timeout_o    = 1'b0;
    set_unwanted_o   = 1'b0;
    reset_req_o      = 1'b0;
    evt_id_o         = '0;

    // Any in-use entry with an exhausted budget has timed out
    for (int i = 0; i < rd_guard_pkg::ID_CAPACITY; i++) begin
      if (!entry_free_q_i[i] && (entry_budget_q_i[i] == '0)) begin
        set_timeout_o = 1'b1;
        evt_id_o      = entry_id_q_i[i];
      end
    end

    // Last beat for an ID nobody asked for
    if (r_done_i && !set_timeout_o && !rsp_hit_i) begin
      set_unwanted_o = 1'b1;
      evt_id_o       = r_id_i;
    end

    reset_req_o = set_timeout_o | set_unwanted_o;

    // Enqueue: bump a matching entry, else claim the lowest free slot
    if (ar_fire_i) begin
      if (ar_match_i) begin
        entry_num_d_o[ar_match_idx_i] = entry_num_q_i[ar_match_idx_i] + 1'b1;
      end else if (!full_i) begin
        entry_id_d_o[free_idx_i]     = ar_id_i;
        entry_num_d_o[free_idx_i]    = {{(rd_guard_pkg::NUM_TXN_W-1){1'b0}}, 1'b1};
        entry_budget_d_o[free_idx_i] = budget_i;
        entry_free_d_o[free_idx_i]   = 1'b0;
      end
    end

    // Dequeue works on the enqueued value so a same-cycle AR is not lost
    if (r_done_i && rsp_hit_i && !set_timeout_o) begin
      if (entry_num_d_o[rsp_idx_i] == {{(rd_guard_pkg::NUM_TXN_W-1){1'b0}}, 1'b1}) begin
        entry_id_d_o[rsp_idx_i]     = '0;
        entry_num_d_o[rsp_idx_i]    = '0;
        entry_budget_d_o[rsp_idx_i] = '0;
        entry_free_d_o[rsp_idx_i]   = 1'b1;
      end else begin
        entry_num_d_o[rsp_idx_i] = entry_num_d_o[rsp_idx_i] - 1'b1;
      end
    end

    // Error recovery drops every tracked transaction
    if (reset_req_o) begin
      entry_id_d_o     = '0;
      entry_num_d_o    = '0;
      entry_budget_d_o = '0;
      entry_free_d_o   = '1;
    end
  end

endmodule

//--- hdl/rd_guard_regs.sv
// Read guard register bank: status, latency budget and reset-cause count
`timescale 1ns/1ps

module rd_guard_regs (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             reg_we_i,
  input  logic                             reg_re_i,
  input  logic [rd_guard_pkg::REG_AW-1:0]  reg_addr_i,
  input  logic [rd_guard_pkg::REG_DW-1:0]  reg_wdata_i,
  input  logic                             set_timeout_i,
  input  logic                             set_unwanted_i,
  input  logic                             reset_req_i,
  input  logic [rd_guard_pkg::ID_W-1:0]    evt_id_i,
  output logic [rd_guard_pkg::REG_DW-1:0]  reg_rdata_o,
  output logic [rd_guard_pkg::CNT_W-1:0]   budget_o,
  output logic                             irq_o
);

  rd_guard_pkg::rd_status_u status_q, status_d;
  logic [rd_guard_pkg::CNT_W-1:0]     budget_q;
  logic [rd_guard_pkg::RST_CNT_W-1:0] rst_cnt_q, rst_cnt_d;

  // Status: write 1 to clear, hardware events win
  always_comb begin
    status_d = status_q;
    if (reg_we_i && (reg_addr_i == rd_guard_pkg::ADDR_STATUS)) begin
      status_d.raw = status_q.raw & ~reg_wdata_i;
    end
    if (set_timeout_i) begin
      status_d.fields.rd_timeout = 1'b1;
      status_d.fields.irq        = 1'b1;
      status_d.fields.txn_id     = evt_id_i;
    end
    if (set_unwanted_i) begin
      status_d.fields.unwanted_rd_resp = 1'b1;
      status_d.fields.irq              = 1'b1;
      status_d.fields.txn_id           = evt_id_i;
    end
  end

  // Count of table clears, any write zeroes it
  always_comb begin
    rst_cnt_d = rst_cnt_q;
    if (reg_we_i && (reg_addr_i == rd_guard_pkg::ADDR_RESET)) begin
      rst_cnt_d = '0;
    end
    if (reset_req_i) begin
      rst_cnt_d = rst_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      status_q  <= '0;
      budget_q  <= rd_guard_pkg::BUDGET_RESET;
      rst_cnt_q <= '0;
    end else begin
      status_q  <= status_d;
      rst_cnt_q <= rst_cnt_d;
      if (reg_we_i && (reg_addr_i == rd_guard_pkg::ADDR_BUDGET)) begin
        budget_q <= reg_wdata_i[rd_guard_pkg::CNT_W-1:0];
      end
    end
  end

  // Read data follows the address in the strobe cycle
  always_comb begin
    reg_rdata_o = '0;
    if (reg_re_i) begin
      case (reg_addr_i)
        rd_guard_pkg::ADDR_STATUS: reg_rdata_o = status_q.raw;
        rd_guard_pkg::ADDR_BUDGET:
          reg_rdata_o = {{(rd_guard_pkg::REG_DW-rd_guard_pkg::CNT_W){1'b0}}, budget_q};
        rd_guard_pkg::ADDR_RESET:
          reg_rdata_o = {{(rd_guard_pkg::REG_DW-rd_guard_pkg::RST_CNT_W){1'b0}}, rst_cnt_q};
        default: reg_rdata_o = '0;
      endcase
    end
  end

  assign budget_o = budget_q;
  assign irq_o    = status_q.fields.irq;

endmodule

//--- hdl/rd_guard_top.sv
// Read guard top level joining the ID table, transaction manager and register bank
`timescale 1ns/1ps

module rd_guard_top (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             ar_valid_i,
  input  logic                             ar_ready_i,
  input  logic [rd_guard_pkg::ID_W-1:0]    ar_id_i,
  input  logic                             r_valid_i,
  input  logic                             r_ready_i,
  input  logic                             r_last_i,
  input  logic [rd_guard_pkg::ID_W-1:0]    r_id_i,
  input  logic                             reg_we_i,
  input  logic                             reg_re_i,
  input  logic [rd_guard_pkg::REG_AW-1:0]  reg_addr_i,
  input  logic [rd_guard_pkg::REG_DW-1:0]  reg_wdata_i,
  output logic [rd_guard_pkg::REG_DW-1:0]  reg_rdata_o,
  output logic                             irq_o
);

  logic ar_fire;
  logic r_done;

  logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::ID_W-1:0]      entry_id_q, entry_id_d;
  logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::NUM_TXN_W-1:0] entry_num_q, entry_num_d;
  logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::CNT_W-1:0]     entry_budget_q;
  logic [rd_guard_pkg::ID_CAPACITY-1:0][rd_guard_pkg::CNT_W-1:0]     entry_budget_d;
  logic [rd_guard_pkg::ID_CAPACITY-1:0]                              entry_free_q, entry_free_d;

  logic                           ar_match, full, rsp_hit;
  logic [rd_guard_pkg::IDX_W-1:0] ar_match_idx, free_idx, rsp_idx;
  logic                           set_timeout, set_unwanted, reset_req;
  logic [rd_guard_pkg::ID_W-1:0]  evt_id;
  logic [rd_guard_pkg::CNT_W-1:0] budget;

  // Address handshake, and the last beat of a response
  assign ar_fire = ar_valid_i & ar_ready_i;
  assign r_done  = r_valid_i & r_ready_i & r_last_i;

  rd_id_table u_id_table (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ar_id_i          (ar_id_i),
    .r_id_i           (r_id_i),
    .entry_id_d_i     (entry_id_d),
    .entry_num_d_i    (entry_num_d),
    .entry_budget_d_i (entry_budget_d),
    .entry_free_d_i   (entry_free_d),
    .entry_id_q_o     (entry_id_q),
    .entry_num_q_o    (entry_num_q),
    .entry_budget_q_o (entry_budget_q),
    .entry_free_q_o   (entry_free_q),
    .ar_match_o       (ar_match),
    .ar_match_idx_o   (ar_match_idx),
    .full_o           (full),
    .free_idx_o       (free_idx),
    .rsp_hit_o        (rsp_hit),
    .rsp_idx_o        (rsp_idx)
  );

  rd_txn_manager u_txn_manager (
    .ar_fire_i        (ar_fire),
    .r_done_i         (r_done),
    .ar_id_i          (ar_id_i),
    .r_id_i           (r_id_i),
    .budget_i         (budget),
    .entry_id_q_i     (entry_id_q),
    .entry_num_q_i    (entry_num_q),
    .entry_budget_q_i (entry_budget_q),
    .entry_free_q_i   (entry_free_q),
    .ar_match_i       (ar_match),
    .ar_match_idx_i   (ar_match_idx),
    .full_i           (full),
    .free_idx_i       (free_idx),
    .rsp_hit_i        (rsp_hit),
    .rsp_idx_i        (rsp_idx),
    .entry_id_d_o     (entry_id_d),
    .entry_num_d_o    (entry_num_d),
    .entry_budget_d_o (entry_budget_d),
    .entry_free_d_o   (entry_free_d),
    .set_timeout_o    (set_timeout),
    .set_unwanted_o   (set_unwanted),
    .reset_req_o      (reset_req),
    .evt_id_o         (evt_id)
  );

  rd_guard_regs u_regs (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .reg_we_i       (reg_we_i),
    .reg_re_i       (reg_re_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .set_timeout_i  (set_timeout),
    .set_unwanted_i (set_unwanted),
    .reset_req_i    (reset_req),
    .evt_id_i       (evt_id),
    .reg_rdata_o    (reg_rdata_o),
    .budget_o       (budget),
    .irq_o          (irq_o)
  );

endmodule

//--- tests/rd_guard_clk_gen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module rd_guard_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset held for the first 10 cycles
  initial begin
    rst_n_o <= 1'b0;
    repeat (10) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- tests/rd_guard_properties.sv
// Concurrent checks on the read guard top level: reset irq, read data, status reserved bits
`timescale 1ns/1ps

module rd_guard_properties (
  input logic                            clk_i,
  input logic                            rst_n_i,
  input logic                            reg_re_i,
  input logic [rd_guard_pkg::REG_AW-1:0] reg_addr_i,
  input logic [rd_guard_pkg::REG_DW-1:0] reg_rdata_i,
  input logic                            irq_i
);

  // Interrupt stays low while reset holds
  irq_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !irq_i)
    else $error("irq_o high during reset");

  rdata_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_re_i |-> !$isunknown(reg_rdata_i))
    else $error("reg_rdata_o has unknown bits during a read");

  // Only the three flags and the ID field may be set
  status_rsvd_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (reg_re_i && (reg_addr_i == rd_guard_pkg::ADDR_STATUS)) |->
      ((reg_rdata_i[rd_guard_pkg::REG_DW-1:rd_guard_pkg::ID_W+4] == '0) && !reg_rdata_i[3]))
    else $error("status reserved bits set on read");

endmodule

//--- tests/rd_guard_tb.sv
// Read guard testbench: file-driven stimulus, value checks and per-test report
`timescale 1ns/1ps

module rd_guard_tb;

  logic                            clk;
  logic                            rst_n;
  logic                            ar_valid;
  logic                            ar_ready;
  logic [rd_guard_pkg::ID_W-1:0]   ar_id;
  logic                            r_valid;
  logic                            r_ready;
  logic                            r_last;
  logic [rd_guard_pkg::ID_W-1:0]   r_id;
  logic                            reg_we;
  logic                            reg_re;
  logic [rd_guard_pkg::REG_AW-1:0] reg_addr;
  logic [rd_guard_pkg::REG_DW-1:0] reg_wdata;
  logic [rd_guard_pkg::REG_DW-1:0] reg_rdata;
  logic                            irq;

  // Operations parsed from the test file
  int          test_q[$];
  logic [63:0] op_q[$];
  logic [31:0] arg_a_q[$];
  logic [31:0] arg_b_q[$];

  int cycle_limit = 0;
  int cur_test;
  int test_checks;
  int test_errors;
  int total_checks;
  int total_errors;
  int tests_run;
  int tests_failed;

  rd_guard_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rd_guard_top dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .ar_valid_i  (ar_valid),
    .ar_ready_i  (ar_ready),
    .ar_id_i     (ar_id),
    .r_valid_i   (r_valid),
    .r_ready_i   (r_ready),
    .r_last_i    (r_last),
    .r_id_i      (r_id),
    .reg_we_i    (reg_we),
    .reg_re_i    (reg_re),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .irq_o       (irq)
  );

  bind rd_guard_top rd_guard_properties u_properties (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_rdata_i (reg_rdata_o),
    .irq_i       (irq_o)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    test_checks++;
    if (actual !== expected) begin
      test_errors++;
      $display("[ERROR] test %0d %s: got 0x%h, expected 0x%h",
               cur_test, name, actual, expected);
    end
  endtask

  // Next rising edge with all strobes dropped
  task automatic next_cycle();
    @(posedge clk);
    ar_valid <= 1'b0;
    ar_ready <= 1'b0;
    r_valid  <= 1'b0;
    r_ready  <= 1'b0;
    r_last   <= 1'b0;
    reg_we   <= 1'b0;
    reg_re   <= 1'b0;
  endtask

  task automatic run_op(input logic [63:0] op, input logic [31:0] arg_a,
                        input logic [31:0] arg_b);
    if (op == 64'("IDLE")) begin
      repeat (arg_a) next_cycle();
    end else begin
      next_cycle();
      if (op == 64'("AR")) begin
        ar_valid <= 1'b1;
        ar_ready <= 1'b1;
        ar_id    <= arg_a[rd_guard_pkg::ID_W-1:0];
      end else if (op == 64'("R")) begin
        r_valid <= 1'b1;
        r_ready <= 1'b1;
        r_last  <= 1'b1;
        r_id    <= arg_a[rd_guard_pkg::ID_W-1:0];
      end else if (op == 64'("WR")) begin
        reg_we    <= 1'b1;
        reg_addr  <= arg_a[rd_guard_pkg::REG_AW-1:0];
        reg_wdata <= arg_b;
      end else if (op == 64'("RD")) begin
        reg_re   <= 1'b1;
        reg_addr <= arg_a[rd_guard_pkg::REG_AW-1:0];
        // Read data is combinational, settled by mid-cycle
        @(negedge clk);
        check_value("reg_rdata_o", reg_rdata, arg_b);
      end else if (op == 64'("CHK")) begin
        @(negedge clk);
        check_value("irq_o", {31'b0, irq}, arg_a);
      end else begin
        test_errors++;
        $display("Test %0d: unknown operation in the test file", cur_test);
      end
    end
  endtask

  task automatic report_test();
    tests_run++;
    total_checks += test_checks;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("Test %0d done: %0d checks ok", cur_test, test_checks);
    end else begin
      tests_failed++;
      $display("Test %0d done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  // Watchdog sized from the loaded test list
  initial begin
    wait (cycle_limit > 0);
    repeat (cycle_limit) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
    $display("Regression failed");
    $finish;
  end

  initial begin
    int          fd;
    int          num;
    int          idle_sum;
    string       line;
    logic [63:0] op_word;
    logic [31:0] a_val;
    logic [31:0] b_val;

    ar_valid  <= 1'b0;
    ar_ready  <= 1'b0;
    ar_id     <= '0;
    r_valid   <= 1'b0;
    r_ready   <= 1'b0;
    r_last    <= 1'b0;
    r_id      <= '0;
    reg_we    <= 1'b0;
    reg_re    <= 1'b0;
    reg_addr  <= '0;
    reg_wdata <= '0;
    test_checks  = 0;
    test_errors  = 0;
    total_checks = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    idle_sum     = 0;

    fd = $fopen("tests/rd_guard_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file tests/rd_guard_tests.txt");
      total_errors = 1;
    end else begin
      // Comment and blank lines fail the scan and are skipped
      while ($fgets(line, fd) > 0) begin
        if ($sscanf(line, "%d %s %h %h", num, op_word, a_val, b_val) == 4) begin
          test_q.push_back(num);
          op_q.push_back(op_word);
          arg_a_q.push_back(a_val);
          arg_b_q.push_back(b_val);
          if (op_word == 64'("IDLE")) begin
            idle_sum += int'(a_val);
          end
        end
      end
      $fclose(fd);
      if (test_q.size() == 0) begin
        $display("The test file holds no operations");
        total_errors = 1;
      end
    end

    if (test_q.size() > 0) begin
      cycle_limit = idle_sum + 50 * test_q.size();
      wait (rst_n === 1'b1);
      cur_test = test_q[0];
      foreach (test_q[i]) begin
        if (test_q[i] != cur_test) begin
          report_test();
          cur_test = test_q[i];
        end
        run_op(op_q[i], arg_a_q[i], arg_b_q[i]);
      end
      report_test();
      next_cycle();
    end

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- tests/rd_guard_tests.txt
# test op arg_a arg_b, all arguments hex
# AR/R: arg_a = ID; IDLE: arg_a = cycles; WR: addr data; RD: addr expected; CHK: expected irq
1 RD   0  0
1 RD   4  14
1 CHK  0  0
2 AR   5  0
2 R    5  0
2 AR   6  0
2 AR   6  0
2 R    6  0
2 R    6  0
2 CHK  0  0
2 R    6  0
2 RD   0  65
2 WR   0  ff
2 WR   8  0
3 AR   3  0
3 IDLE 19 0
3 CHK  1  0
3 RD   0  36
3 RD   8  1
3 WR   0  ff
3 WR   8  0
4 R    9  0
4 RD   0  95
4 WR   0  ff
4 CHK  0  0
5 WR   4  5
5 AR   2  0
5 IDLE 0a 0
5 RD   0  26
5 WR   0  ff
5 WR   4  14
5 AR   2  0
5 IDLE 0a 0
5 R    2  0
5 CHK  0  0
6 AR   1  0
6 AR   2  0
6 AR   3  0
6 AR   4  0
6 AR   5  0
6 R    1  0
6 R    2  0
6 R    3  0
6 R    4  0
6 CHK  0  0
6 R    5  0
6 RD   0  55

//--- rd_guard.f
hdl/rd_guard_pkg.sv
hdl/rd_id_table.sv
hdl/rd_txn_manager.sv
hdl/rd_guard_regs.sv
hdl/rd_guard_top.sv
tests/rd_guard_clk_gen.sv
tests/rd_guard_properties.sv
tests/rd_guard_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the read guard testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rd_guard_tb \
  -f rd_guard.f -o rd_guard_sim

output=$(./obj_dir/rd_guard_sim)
echo "$output"
echo "$output" | grep -qx "Regression passed"
